// File: Bender.yml
package:
  name: nn_layer

sources:
  # Packages
  - files:
      - hw/nnTypesPkg.sv
      - hw/nnWeightsPkg.sv
  # RTL
  - files:
      - hw/wbFrontEnd.sv
      - hw/neuronNode.sv
      - hw/denseLayer.sv
      - hw/resultBank.sv
      - hw/nnLayerTop.sv
  # Testbench
  - target: test
    files:
      - verification/clockGen.sv
      - verification/nnLayer_props.sv
      - verification/nnLayerTb.sv

// File: hw/denseLayer.sv
`timescale 1ns/100ps
`default_nettype none

module denseLayer (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actVector_t activations,
	input logic start,
	output nnTypesPkg::layerOut_t layerResult
);

	import nnTypesPkg::*;

	wire [numNodes-1:0][actWidth-1:0] nodeResults;

	// Three stages to match input register, accumulator and output register
	logic [2:0] validPipe;

	for (genvar n = 0; n < numNodes; n++)
	begin : genNode
		neuronNode #(
			.nodeIndex(n)
		) node (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.result(nodeResults[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], start};
	end

	assign layerResult = '{valid: validPipe[2], results: nodeResults};

endmodule

`default_nettype wire

// File: hw/neuronNode.sv
`timescale 1ns/100ps
`default_nettype none

module neuronNode #(
	parameter int nodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actVector_t activations,
	output logic [nnTypesPkg::actWidth-1:0] result
);

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	actVector_t actReg;
	logic signed [accWidth-1:0] sumNext;
	logic signed [accWidth-1:0] acc;
	logic [actWidth:0] rounded;
	logic overRange;

	// Stage 1 captures the inputs, stage 2 holds the accumulated sum
	always_ff @(posedge clk)
	begin
		actReg <= activations;
		acc <= sumNext;
	end

	// All operands are signed so each product is sign extended to the accumulator width
	always_comb
	begin
		sumNext = biases[nodeIndex];
		for (int i = 0; i < numInputs; i++)
		begin
			sumNext += weights[nodeIndex][i] * signed'(actReg[i]);
		end
	end

	// Drop fracShift fraction bits and round half up using the highest dropped bit
	assign rounded = {1'b0, acc[fracShift+actWidth-1:fracShift]}
		+ {{actWidth{1'b0}}, acc[fracShift-1]};

	assign overRange = (acc[accWidth-2:fracShift+actWidth] != '0) || (rounded > outMax);

	// Stage 3 applies the ReLU and clamps at the largest positive output
	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (acc[accWidth-1])
			result <= '0;
		else if (overRange)
			result <= outMax;
		else
			result <= rounded[actWidth-1:0];
	end

endmodule

`default_nettype wire

// File: hw/nnLayerTop.sv
`timescale 1ns/100ps
`default_nettype none

module nnLayerTop (
	input logic clk,
	input logic reset,
	input nnTypesPkg::wbReq_t wbIn,
	output nnTypesPkg::wbRsp_t wbOut
);

	import nnTypesPkg::*;

	actVector_t activations;
	logic start;
	logic [addrWidth-1:0] readAddr;
	logic [wbDataWidth-1:0] readData;
	layerOut_t layerResult;

	wbFrontEnd frontEnd (
		.clk(clk),
		.reset(reset),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.activations(activations),
		.start(start),
		.readAddr(readAddr),
		.readData(readData)
	);

	denseLayer layer (
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.start(start),
		.layerResult(layerResult)
	);

	// The start pulse also clears the done flag
	resultBank results (
		.clk(clk),
		.reset(reset),
		.layerResult(layerResult),
		.start(start),
		.readAddr(readAddr),
		.readData(readData)
	);

endmodule

`default_nettype wire

// File: hw/nnTypesPkg.sv
`default_nettype none

package nnTypesPkg;

	// Layer dimensions and fixed-point formats
	localparam int numInputs = 15;
	localparam int numNodes = 4;
	localparam int actWidth = 8;
	localparam int accWidth = 23;
	localparam int fracShift = 6;
	localparam logic [actWidth-1:0] outMax = {1'b0, {(actWidth - 1){1'b1}}};

	// Wishbone word addresses and data width
	localparam int addrWidth = 6;
	localparam int wbDataWidth = 32;
	localparam logic [addrWidth-1:0] addrActBase = 6'd0;
	localparam logic [addrWidth-1:0] addrCtrl = 6'd16;
	localparam logic [addrWidth-1:0] addrResultBase = 6'd32;

	typedef logic signed [actWidth-1:0] activation_t;
	typedef activation_t [numInputs-1:0] actVector_t;

	typedef struct packed {
		logic valid;
		logic [numNodes-1:0][actWidth-1:0] results;
	} layerOut_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [addrWidth-1:0] adr;
		logic [wbDataWidth-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [wbDataWidth-1:0] dat;
	} wbRsp_t;

endpackage

`default_nettype wire

// File: hw/nnWeightsPkg.sv
`default_nettype none

package nnWeightsPkg;

	import nnTypesPkg::*;

	localparam int biasWidth = 16;

	// One row per neuron, one column per activation
	localparam logic signed [actWidth-1:0] weights [numNodes][numInputs] = '{
		'{8'sd7, -8'sd8, -8'sd18, -8'sd26, 8'sd29, 8'sd10, 8'sd22, -8'sd31,
			8'sd13, -8'sd7, 8'sd17, 8'sd24, 8'sd1, 8'sd17, -8'sd9},
		'{-8'sd12, 8'sd5, 8'sd19, -8'sd3, 8'sd8, -8'sd21, 8'sd14, 8'sd6,
			-8'sd17, 8'sd11, 8'sd3, -8'sd9, 8'sd25, -8'sd4, 8'sd16},
		'{8'sd20, -8'sd15, 8'sd4, 8'sd9, -8'sd6, 8'sd13, -8'sd27, 8'sd18,
			8'sd2, -8'sd11, -8'sd5, 8'sd7, -8'sd14, 8'sd23, 8'sd10},
		'{-8'sd3, 8'sd12, -8'sd7, 8'sd15, 8'sd21, -8'sd2, 8'sd6, -8'sd19,
			8'sd9, 8'sd26, -8'sd13, -8'sd8, 8'sd4, 8'sd11, -8'sd16}
	};

	// Bias is in the same scale as the raw products
	localparam logic signed [biasWidth-1:0] biases [numNodes] = '{
		16'sd0,
		16'sd320,
		-16'sd256,
		16'sd96
	};

endpackage

`default_nettype wire

// File: hw/resultBank.sv
`timescale 1ns/100ps
`default_nettype none

module resultBank (
	input logic clk,
	input logic reset,
	input nnTypesPkg::layerOut_t layerResult,
	input logic start,
	input logic [nnTypesPkg::addrWidth-1:0] readAddr,
	output logic [nnTypesPkg::wbDataWidth-1:0] readData
);

	import nnTypesPkg::*;

	logic [numNodes-1:0][actWidth-1:0] resultRegs;
	logic done;
	logic [addrWidth-1:0] resultSel;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultRegs <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (layerResult.valid)
				resultRegs <= layerResult.results;
			// A new start wins so done always refers to the latest request
			if (start)
				done <= 1'b0;
			else if (layerResult.valid)
				done <= 1'b1;
		end
	end

	assign resultSel = readAddr - addrResultBase;

	always_comb
	begin
		readData = '0;
		if (readAddr == addrCtrl)
			readData[0] = done;
		else if (readAddr >= addrResultBase && readAddr < addrResultBase + numNodes)
			readData[actWidth-1:0] = resultRegs[resultSel];
	end

endmodule

`default_nettype wire

// File: hw/wbFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module wbFrontEnd (
	input logic clk,
	input logic reset,
	input nnTypesPkg::wbReq_t wbIn,
	output nnTypesPkg::wbRsp_t wbOut,
	output nnTypesPkg::actVector_t activations,
	output logic start,
	output logic [nnTypesPkg::addrWidth-1:0] readAddr,
	input logic [nnTypesPkg::wbDataWidth-1:0] readData
);

	import nnTypesPkg::*;

	logic ackReg;
	logic startReg;
	logic request;
	logic writeReq;
	logic actHit;
	logic [wbDataWidth-1:0] readReg;
	actVector_t actRegs;

	// A new access is one that has not been acknowledged yet
	assign request = wbIn.cyc && wbIn.stb && !ackReg;
	assign writeReq = request && wbIn.we;
	assign actHit = (wbIn.adr >= addrActBase) && (wbIn.adr < addrActBase + numInputs);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ackReg <= 1'b0;
			startReg <= 1'b0;
			actRegs <= '0;
		end
		else
		begin
			ackReg <= request;
			startReg <= writeReq && (wbIn.adr == addrCtrl);
			if (writeReq && actHit)
				actRegs[wbIn.adr - addrActBase] <= wbIn.dat[actWidth-1:0];
		end
	end

	// Read data is sampled with the request and presented with ack
	always_ff @(posedge clk)
	begin
		if (request && !wbIn.we)
			readReg <= readData;
	end

	assign readAddr = wbIn.adr;
	assign activations = actRegs;
	assign start = startReg;
	assign wbOut = '{ack: ackReg, dat: readReg};

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int period = 40,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

	// Reset drops on a rising edge once the requested cycles have passed
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verification/nnLayerTb.sv
`timescale 1ns/100ps
`default_nettype none

module nnLayerTb;

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	localparam int numRandom = 50;
	localparam int numTests = numRandom + 8;
	localparam int cyclesPerTest = 200;
	localparam int maxPolls = 20;
	localparam logic [addrWidth-1:0] unmappedAddrs [5] = '{6'd15, 6'd17, 6'd31, 6'd36, 6'd63};

	logic clk;
	logic reset;
	wbReq_t wbIn;
	wbRsp_t wbOut;
	logic [31:0] rngState;
	logic [actWidth-1:0] lastResults [numNodes];
	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];
	int checkCount = 0;
	int errorCount = 0;
	int errorsBefore = 0;
	int testCount = 0;
	int failedTests = 0;

	clockGen #(.period(40), .resetCycles(5)) clocks (.clk(clk), .reset(reset));

	nnLayerTop dut (.clk(clk), .reset(reset), .wbIn(wbIn), .wbOut(wbOut));

	// Sum of products plus bias, then ReLU, round half up on bit 5 and clamp at 127
	function automatic logic [actWidth-1:0] nodeModel(input actVector_t act, input int node);
		int sum;
		int w;
		int x;
		int r;
		sum = biases[node];
		for (int i = 0; i < numInputs; i++)
		begin
			w = weights[node][i];
			x = act[i];
			sum += w * x;
		end
		if (sum < 0)
			return '0;
		if (sum >= 2 ** (fracShift + actWidth))
			return 8'd127;
		r = (sum >> fracShift) + ((sum >> (fracShift - 1)) & 1);
		if (r > 127)
			r = 127;
		return r[actWidth-1:0];
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic busAccess(input logic write, input logic [addrWidth-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge clk);
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = write;
		wbIn.adr = adr;
		wbIn.dat = wdata;
		@(negedge clk);
		while (!wbOut.ack)
			@(negedge clk);
		rdata = wbOut.dat;
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we = 1'b0;
	endtask

	task automatic busWrite(input logic [addrWidth-1:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, adr, data, unused);
	endtask

	task automatic busRead(input logic [addrWidth-1:0] adr, output logic [31:0] data);
		busAccess(1'b0, adr, 32'h0, data);
	endtask

	task automatic expectValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		actQ.push_back(actual);
	endtask

	task automatic writeVector(input actVector_t vec);
		for (int i = 0; i < numInputs; i++)
			busWrite(addrWidth'(addrActBase + i), {24'h0, vec[i]});
	endtask

	task automatic pollDone();
		logic [31:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[0] && polls < maxPolls)
		begin
			busRead(addrCtrl, status);
			polls++;
		end
		assert (status[0])
		else
		begin
			$display("Done flag did not come up within %0d status reads", maxPolls);
			errorCount++;
		end
	endtask

	task automatic checkResults(input actVector_t vec);
		logic [31:0] data;
		for (int n = 0; n < numNodes; n++)
		begin
			busRead(addrWidth'(addrResultBase + n), data);
			lastResults[n] = data[actWidth-1:0];
			expectValue($sformatf("result[%0d]", n), {24'h0, nodeModel(vec, n)}, data);
		end
	endtask

	task automatic runInference(input actVector_t vec);
		writeVector(vec);
		busWrite(addrCtrl, 32'h1);
		pollDone();
		checkResults(vec);
	endtask

	// Narrow vectors keep most sums inside the unsaturated range
	task automatic randomVector(input logic narrow, output actVector_t vec);
		for (int i = 0; i < numInputs; i++)
		begin
			rngState = xorshift32(rngState);
			vec[i] = narrow ? {{2{rngState[5]}}, rngState[5:0]} : rngState[7:0];
		end
	endtask

	task automatic finishTest(input string name);
		while (actQ.size() > 0)
			@(negedge clk);
		testCount++;
		if (errorCount == errorsBefore)
			$display("Test %0d %s: pass", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: FAIL, %0d errors", testCount, name, errorCount - errorsBefore);
		end
		errorsBefore = errorCount;
	endtask

	always @(negedge clk)
	begin : compare
		string name;
		logic [31:0] expected;
		logic [31:0] actual;
		while (actQ.size() > 0)
		begin
			name = nameQ.pop_front();
			expected = expQ.pop_front();
			actual = actQ.pop_front();
			checkCount++;
			assert (actual === expected)
			else
			begin
				$display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
				errorCount++;
			end
		end
	end

	initial
	begin : watchdog
		repeat (numTests * cyclesPerTest)
			@(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", numTests * cyclesPerTest);
		$display("Something failed");
		$finish;
	end

	initial
	begin : stimulus
		actVector_t vec;
		logic [31:0] data;
		wbIn = '0;
		rngState = 32'hb2ee;
		@(negedge clk);
		while (reset)
			@(negedge clk);

		busRead(addrCtrl, data);
		expectValue("status", 32'h0, data);
		for (int n = 0; n < numNodes; n++)
		begin
			busRead(addrWidth'(addrResultBase + n), data);
			expectValue($sformatf("result[%0d]", n), 32'h0, data);
		end
		finishTest("reset values");

		vec = '0;
		runInference(vec);
		finishTest("all zero");
		for (int i = 0; i < numInputs; i++)
			vec[i] = 8'sd1;
		runInference(vec);
		finishTest("all ones");
		for (int i = 0; i < numInputs; i++)
			vec[i] = (i % 2) ? activation_t'(-5 * i) : activation_t'(7 * i);
		runInference(vec);
		finishTest("mixed signs");

		// Match or oppose every weight sign of node 0 at full scale
		for (int i = 0; i < numInputs; i++)
			vec[i] = (weights[0][i] < 0) ? 8'h80 : 8'h7f;
		runInference(vec);
		expectValue("result[0]", 32'd127, {24'h0, lastResults[0]});
		finishTest("positive saturation");
		for (int i = 0; i < numInputs; i++)
			vec[i] = (weights[0][i] < 0) ? 8'h7f : 8'h80;
		runInference(vec);
		expectValue("result[0]", 32'd0, {24'h0, lastResults[0]});
		finishTest("negative clamp");

		for (int t = 0; t < numRandom; t++)
		begin
			randomVector(t % 2, vec);
			runInference(vec);
			finishTest($sformatf("random vector %0d", t));
		end

		busRead(addrCtrl, data);
		expectValue("status", 32'h1, data);
		randomVector(1'b1, vec);
		writeVector(vec);
		busWrite(addrCtrl, 32'h1);
		busRead(addrCtrl, data);
		expectValue("status", 32'h0, data);
		pollDone();
		checkResults(vec);
		finishTest("start clears done");

		foreach (unmappedAddrs[k])
		begin
			busRead(unmappedAddrs[k], data);
			expectValue($sformatf("read 0x%02h", unmappedAddrs[k]), 32'h0, data);
			busWrite(unmappedAddrs[k], 32'hffff_ffff);
		end
		busRead(addrCtrl, data);
		expectValue("status", 32'h1, data);
		for (int n = 0; n < numNodes; n++)
		begin
			busRead(addrWidth'(addrResultBase + n), data);
			expectValue($sformatf("result[%0d]", n), {24'h0, nodeModel(vec, n)}, data);
		end
		finishTest("unmapped addresses");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d, bus protocol violations %0d",
			testCount, failedTests, checkCount, errorCount, dut.frontEnd.props.violations);
		if (errorCount == 0 && dut.frontEnd.props.violations == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/nnLayer_props.sv
`timescale 1ns/100ps
`default_nettype none

module nnLayerProps (
	input logic clk,
	input logic reset,
	input nnTypesPkg::wbReq_t wbIn,
	input nnTypesPkg::wbRsp_t wbOut,
	input logic start
);

	import nnTypesPkg::*;

	int violations = 0;

	// Without wait states every access gets a single ack cycle
	ackOneCycle: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |=> !wbOut.ack)
	else
	begin
		$error("ack stayed high for two cycles");
		violations++;
	end

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |-> $past(wbIn.cyc && wbIn.stb && !wbOut.ack))
	else
	begin
		$error("ack without a new request in the previous cycle");
		violations++;
	end

	startOnCtrlWrite: assert property (@(posedge clk) disable iff (reset)
		start |-> wbOut.ack && $past(wbIn.cyc && wbIn.stb && wbIn.we && wbIn.adr == addrCtrl))
	else
	begin
		$error("start pulse without an acknowledged control write");
		violations++;
	end

endmodule

bind wbFrontEnd nnLayerProps props (
	.clk(clk),
	.reset(reset),
	.wbIn(wbIn),
	.wbOut(wbOut),
	.start(start)
);

`default_nettype wire

// File: vlog.f
hw/nnTypesPkg.sv
hw/nnWeightsPkg.sv
hw/wbFrontEnd.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/resultBank.sv
hw/nnLayerTop.sv
verification/clockGen.sv
verification/nnLayer_props.sv
verification/nnLayerTb.sv
